// File: sources.f
+incdir+source
source/i3c_flow_pkg.sv
source/cmd_decoder.sv
source/dat_reader.sv
source/flow_sequencer.sv
source/i2c_fmt_writer.sv
source/resp_writer.sv
source/i3c_flow_top.sv
dv/tb_clk_gen.sv
dv/tb_i3c_flow.sv

// File: Bender.yml
package:
  name: i3c_flow

sources:
  - include_dirs:
      - source
    files:
      - source/i3c_flow_pkg.sv
      - source/cmd_decoder.sv
      - source/dat_reader.sv
      - source/flow_sequencer.sv
      - source/i2c_fmt_writer.sv
      - source/resp_writer.sv
      - source/i3c_flow_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_i3c_flow.sv

// File: dv/tb_i3c_flow.sv
// ####################################################################
// Directed tests for the I3C active flow, DAT model, sinks, watchdog
// ####################################################################
`timescale 1ns/1ps
`include "i3c_flow_settings.svh"

module tb_i3c_flow
  import i3c_flow_pkg::*;
;

  localparam int          TIMEOUT_CYCLES = 6 * 200;
  localparam logic [31:0] LFSR_SEED      = 32'h7da5d74e;

  logic                  clk_i, rst_ni, enable_i, idle_o;
  logic                  cmd_valid_i, cmd_ready_o;
  logic [`CMD_W-1:0]     cmd_data_i;
  logic                  dat_rd_o;
  logic [`DAT_IDX_W-1:0] dat_idx_o;
  logic [`DAT_W-1:0]     dat_rdata_i;
  logic                  fmt_valid_o, fmt_ready_i, fmt_start_o, fmt_stop_o;
  logic [`BYTE_W-1:0]    fmt_byte_o;
  logic                  resp_valid_o, resp_ready_i;
  logic [`RESP_W-1:0]    resp_data_o;

  // DAT contents and collected traffic
  logic [`DAT_W-1:0] dat_mem [32];
  logic [63:0]       cmd_list [$];
  // Format entries packed as {start, stop, byte}
  logic [9:0]        fmt_q [$];
  logic [9:0]        exp_fmt_q [$];
  logic [31:0]       resp_q [$];
  logic [31:0]       exp_resp_q [$];

  logic [31:0] lfsr_q;
  logic        bp_on;
  logic        cmd_pending;
  int          cycle_cnt, accept_cycle, dat_rd_count;
  logic [4:0]  accept_idx;
  int          error_count, check_count, tests_run, errors_at_start;
  string       cur_test;

  tb_clk_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(10)) tb_clk_gen_i (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  i3c_flow_top i3c_flow_top_i (.*);

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Static address and legacy flag depend on the full index
  function automatic logic [63:0] dat_entry(input logic [4:0] idx);
    logic [63:0] e;
    e = '0;
    e[36:32] = idx;
    // Upper indices are I3C targets
    e[`DAT_LEGACY_BIT] = (idx < 5'd24);
    e[6:0] = 7'h10 + {2'b00, idx};
    return e;
  endfunction

  function automatic logic [63:0] make_desc(input logic [2:0] attr, input logic [3:0] tid,
                                            input logic [4:0] idx, input logic [2:0] dtt,
                                            input logic rnw, input logic toc,
                                            input logic [31:0] data);
    logic [63:0] d;
    d = '0;
    d[`CMD_ATTR] = attr;
    d[`CMD_TID] = tid;
    d[`CMD_DEV_IDX] = idx;
    d[`CMD_DTT] = dtt;
    d[`CMD_RNW] = rnw;
    d[`CMD_TOC] = toc;
    d[63:32] = data;
    return d;
  endfunction

  task automatic check_value(input string label, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count++;
    if (expected !== actual) begin
      $display("MISMATCH %s %s: expected %0h, actual %0h", cur_test, label, expected, actual);
      error_count++;
    end
  endtask

  // DAT answers one cycle after the strobe and drives all ones otherwise
  always @(posedge clk_i) begin
    if (dat_rd_o) begin
      dat_rdata_i <= dat_mem[dat_idx_o];
    end else begin
      dat_rdata_i <= '1;
    end
  end

  // Ready gating with one LFSR step per bit
  always @(posedge clk_i) begin
    if (bp_on) begin
      lfsr_q = lfsr_next(lfsr_q);
      fmt_ready_i <= lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
      resp_ready_i <= lfsr_q[0];
    end else begin
      fmt_ready_i  <= 1'b1;
      resp_ready_i <= 1'b1;
    end
  end

  // Handshake monitor and sinks
  always @(posedge clk_i) begin
    if (rst_ni) begin
      // Idle only while no command is in flight
      check_value("idle_o", !cmd_pending, idle_o);
      if (dat_rd_o) begin
        dat_rd_count++;
        check_value("dat_rd_cycle", accept_cycle + 1, cycle_cnt);
        check_value("dat_idx", accept_idx, dat_idx_o);
      end
      if (fmt_valid_o && fmt_ready_i) begin
        fmt_q.push_back({fmt_start_o, fmt_stop_o, fmt_byte_o});
      end
      if (resp_valid_o && resp_ready_i) begin
        resp_q.push_back(resp_data_o);
        cmd_pending = 1'b0;
      end
      if (cmd_valid_i && cmd_ready_o) begin
        if (cmd_pending) begin
          $display("ERROR %s: command accepted before previous response was taken", cur_test);
          error_count++;
        end
        cmd_pending  = 1'b1;
        accept_cycle = cycle_cnt;
        accept_idx   = cmd_data_i[`CMD_DEV_IDX];
      end
      cycle_cnt++;
    end
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) @(negedge clk_i);
    $display("ERROR %s: timeout after %0d cycles waiting for the DUT", cur_test, cycle_cnt);
    $display("SIMULATION FAILED");
    $finish;
  end

  // Expected stream from the descriptor and DAT entry
  task automatic add_expected(input logic [63:0] desc);
    logic [63:0] entry;
    logic [2:0]  dtt;
    logic        toc;
    int          first, count, k;
    entry = dat_mem[desc[`CMD_DEV_IDX]];
    dtt   = desc[`CMD_DTT];
    toc   = desc[`CMD_TOC];
    if (desc[`CMD_ATTR] == CmdImmediate && !desc[`CMD_RNW] && entry[`DAT_LEGACY_BIT]) begin
      // Defining byte occupies data byte 1
      first = (dtt >= 5) ? 2 : 1;
      count = (dtt >= 5) ? dtt - 5 : dtt;
      exp_fmt_q.push_back({1'b1, (count == 0) & toc, entry[6:0], 1'b0});
      for (k = 0; k < count; k++) begin
        exp_fmt_q.push_back({1'b0, (k == count - 1) & toc, desc[32 + 8 * (first + k - 1) +: 8]});
      end
      exp_resp_q.push_back({RespSuccess, desc[`CMD_TID], 24'h0});
    end else begin
      exp_resp_q.push_back({RespUnsupported, desc[`CMD_TID], 24'h0});
    end
  endtask

  task automatic compare_results();
    logic [9:0] e;
    logic [9:0] a;
    int         i;
    check_value("fmt_count", exp_fmt_q.size(), fmt_q.size());
    if (exp_fmt_q.size() == fmt_q.size()) begin
      for (i = 0; i < fmt_q.size(); i++) begin
        e = exp_fmt_q[i];
        a = fmt_q[i];
        check_value($sformatf("fmt_byte[%0d]", i), e[7:0], a[7:0]);
        check_value($sformatf("fmt_start[%0d]", i), e[9], a[9]);
        check_value($sformatf("fmt_stop[%0d]", i), e[8], a[8]);
      end
    end
    check_value("resp_count", exp_resp_q.size(), resp_q.size());
    if (exp_resp_q.size() == resp_q.size()) begin
      for (i = 0; i < resp_q.size(); i++) begin
        check_value($sformatf("resp_data[%0d]", i), exp_resp_q[i], resp_q[i]);
      end
    end
  endtask

  // Commands back to back with valid held until each is accepted
  task automatic run_batch();
    int i, n;
    n = cmd_list.size();
    fmt_q.delete();
    resp_q.delete();
    exp_fmt_q.delete();
    exp_resp_q.delete();
    for (i = 0; i < n; i++) begin
      add_expected(cmd_list[i]);
    end
    @(posedge clk_i);
    cmd_valid_i <= 1'b1;
    cmd_data_i  <= cmd_list[0];
    for (i = 0; i < n; i++) begin
      do @(posedge clk_i); while (!cmd_ready_o);
      if (i + 1 < n) begin
        cmd_data_i <= cmd_list[i + 1];
      end else begin
        cmd_valid_i <= 1'b0;
      end
    end
    while (resp_q.size() < n) @(negedge clk_i);
    compare_results();
    cmd_list.delete();
  endtask

  task automatic start_test(input string name);
    cur_test        = name;
    errors_at_start = error_count;
  endtask

  task automatic finish_test();
    tests_run++;
    $display("Test %s finished with %0d errors", cur_test, error_count - errors_at_start);
  endtask

  task automatic test_reset_state();
    start_test("reset_state");
    check_value("idle_o", 1, idle_o);
    check_value("cmd_ready_o", 0, cmd_ready_o);
    check_value("dat_rd_o", 0, dat_rd_o);
    check_value("fmt_valid_o", 0, fmt_valid_o);
    check_value("resp_valid_o", 0, resp_valid_o);
    @(posedge clk_i);
    enable_i <= 1'b1;
    @(negedge clk_i);
    check_value("cmd_ready_early", 0, cmd_ready_o);
    // Idle to WaitCmd takes one cycle
    @(negedge clk_i);
    check_value("cmd_ready_o", 1, cmd_ready_o);
    check_value("idle_o", 1, idle_o);
    finish_test();
  endtask

  task automatic test_plain_write();
    start_test("plain_write");
    cmd_list.push_back(make_desc(CmdImmediate, 4'h1, 5'd1, 3'd1, 1'b0, 1'b1, 32'h44332211));
    cmd_list.push_back(make_desc(CmdImmediate, 4'h2, 5'd2, 3'd2, 1'b0, 1'b0, 32'h88776655));
    cmd_list.push_back(make_desc(CmdImmediate, 4'h3, 5'd9, 3'd3, 1'b0, 1'b1, 32'hccbbaa99));
    cmd_list.push_back(make_desc(CmdImmediate, 4'h4, 5'd23, 3'd4, 1'b0, 1'b1, 32'h0fedcbad));
    run_batch();
    finish_test();
  endtask

  task automatic test_def_byte_write();
    start_test("def_byte_write");
    // dtt 5 with toc puts start and stop on the address byte
    cmd_list.push_back(make_desc(CmdImmediate, 4'h5, 5'd4, 3'd5, 1'b0, 1'b1, 32'h13121110));
    cmd_list.push_back(make_desc(CmdImmediate, 4'h6, 5'd5, 3'd5, 1'b0, 1'b0, 32'h23222120));
    cmd_list.push_back(make_desc(CmdImmediate, 4'h7, 5'd6, 3'd6, 1'b0, 1'b1, 32'h33323130));
    cmd_list.push_back(make_desc(CmdImmediate, 4'h8, 5'd7, 3'd7, 1'b0, 1'b1, 32'h43424140));
    run_batch();
    finish_test();
  endtask

  task automatic test_unsupported();
    start_test("unsupported");
    cmd_list.push_back(make_desc(CmdRegular, 4'h9, 5'd1, 3'd2, 1'b0, 1'b1, 32'h55aa55aa));
    cmd_list.push_back(make_desc(CmdCombo, 4'ha, 5'd2, 3'd2, 1'b0, 1'b1, 32'h66bb66bb));
    cmd_list.push_back(make_desc(CmdImmediate, 4'hb, 5'd3, 3'd2, 1'b1, 1'b1, 32'h77cc77cc));
    // Index 28 is an I3C target
    cmd_list.push_back(make_desc(CmdImmediate, 4'hc, 5'd28, 3'd2, 1'b0, 1'b1, 32'h88dd88dd));
    cmd_list.push_back(make_desc(CmdAddrAssign, 4'hd, 5'd3, 3'd0, 1'b0, 1'b1, 32'h0));
    cmd_list.push_back(make_desc(CmdInternal, 4'he, 5'd3, 3'd0, 1'b0, 1'b1, 32'h0));
    run_batch();
    finish_test();
  endtask

  task automatic test_back_pressure();
    start_test("back_pressure");
    @(negedge clk_i);
    bp_on = 1'b1;
    cmd_list.push_back(make_desc(CmdImmediate, 4'h1, 5'd10, 3'd4, 1'b0, 1'b1, 32'hdeadbeef));
    cmd_list.push_back(make_desc(CmdImmediate, 4'h2, 5'd11, 3'd7, 1'b0, 1'b0, 32'hcafef00d));
    cmd_list.push_back(make_desc(CmdRegular, 4'h3, 5'd12, 3'd1, 1'b0, 1'b1, 32'h01020304));
    cmd_list.push_back(make_desc(CmdImmediate, 4'h4, 5'd13, 3'd2, 1'b0, 1'b1, 32'h0a0b0c0d));
    cmd_list.push_back(make_desc(CmdImmediate, 4'h5, 5'd14, 3'd5, 1'b0, 1'b1, 32'h11223344));
    cmd_list.push_back(make_desc(CmdImmediate, 4'h6, 5'd30, 3'd3, 1'b0, 1'b1, 32'h99887766));
    run_batch();
    @(negedge clk_i);
    bp_on = 1'b0;
    finish_test();
  endtask

  task automatic test_dat_timing();
    int reads_before;
    start_test("dat_timing");
    reads_before = dat_rd_count;
    cmd_list.push_back(make_desc(CmdImmediate, 4'h7, 5'd0, 3'd1, 1'b0, 1'b1, 32'h000000a5));
    cmd_list.push_back(make_desc(CmdImmediate, 4'h8, 5'd17, 3'd0, 1'b0, 1'b1, 32'h0));
    cmd_list.push_back(make_desc(CmdImmediate, 4'h9, 5'd31, 3'd1, 1'b0, 1'b1, 32'h0000005a));
    run_batch();
    // One DAT read per command
    check_value("dat_rd_count", 3, dat_rd_count - reads_before);
    finish_test();
  endtask

  initial begin
    enable_i     = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_data_i   = '0;
    dat_rdata_i  = '0;
    fmt_ready_i  = 1'b1;
    resp_ready_i = 1'b1;
    lfsr_q       = LFSR_SEED;
    bp_on        = 1'b0;
    cmd_pending  = 1'b0;
    cycle_cnt    = 0;
    accept_cycle = 0;
    accept_idx   = '0;
    dat_rd_count = 0;
    error_count  = 0;
    check_count  = 0;
    tests_run    = 0;
    cur_test     = "init";
    for (int i = 0; i < 32; i++) begin
      dat_mem[i] = dat_entry(i[4:0]);
    end
    wait (rst_ni);
    @(negedge clk_i);
    test_reset_state();
    test_plain_write();
    test_def_byte_write();
    test_unsupported();
    test_back_pressure();
    test_dat_timing();
    $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, check_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: dv/tb_clk_gen.sv
// ####################################################################
// Testbench clock and active-low reset
// ####################################################################
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD_NS    = 8.0,
  parameter int  RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // Reset released on a rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: source/i3c_flow_top.sv
// ####################################################################
// Active flow top level wiring the decoder through the response queue
// ####################################################################
`timescale 1ns/1ps
`include "i3c_flow_settings.svh"

module i3c_flow_top
  import i3c_flow_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  enable_i,
  output logic                  idle_o,
  // Command queue
  input  logic                  cmd_valid_i,
  input  logic [`CMD_W-1:0]     cmd_data_i,
  output logic                  cmd_ready_o,
  // DAT port
  output logic                  dat_rd_o,
  output logic [`DAT_IDX_W-1:0] dat_idx_o,
  input  logic [`DAT_W-1:0]     dat_rdata_i,
  // I2C format FIFO
  output logic                  fmt_valid_o,
  input  logic                  fmt_ready_i,
  output logic [`BYTE_W-1:0]    fmt_byte_o,
  output logic                  fmt_start_o,
  output logic                  fmt_stop_o,
  // Response queue
  output logic                  resp_valid_o,
  input  logic                  resp_ready_i,
  output logic [`RESP_W-1:0]    resp_data_o
);

  logic                    wait_cmd, cmd_taken, rnw, toc, def_byte;
  logic [`DAT_IDX_W-1:0]   dev_idx;
  logic [3:0]              tid;
  cmd_attr_e               attr;
  logic [2:0]              data_cnt;
  logic [3:0][`BYTE_W-1:0] imm_bytes;
  logic                    fetch, entry_valid, legacy;
  logic [6:0]              static_addr;
  logic                    xfer_start, fmt_done, resp_req, resp_done;
  resp_err_e               resp_err;

  cmd_decoder cmd_decoder_i (
    .clk_i, .rst_ni, .cmd_valid_i, .cmd_data_i, .cmd_ready_o,
    .wait_cmd_i  (wait_cmd),   .cmd_taken_o (cmd_taken), .dev_idx_o  (dev_idx),
    .tid_o       (tid),        .attr_o      (attr),      .rnw_o      (rnw),
    .toc_o       (toc),        .data_cnt_o  (data_cnt),  .def_byte_o (def_byte),
    .imm_bytes_o (imm_bytes)
  );

  dat_reader dat_reader_i (
    .clk_i, .rst_ni, .fetch_i (fetch), .dev_idx_i (dev_idx),
    .dat_rd_o, .dat_idx_o, .dat_rdata_i,
    .entry_valid_o (entry_valid), .static_addr_o (static_addr), .legacy_o (legacy)
  );

  flow_sequencer flow_sequencer_i (
    .clk_i, .rst_ni, .enable_i,
    .cmd_taken_i   (cmd_taken),   .attr_i      (attr),      .rnw_i        (rnw),
    .entry_valid_i (entry_valid), .legacy_i    (legacy),    .fmt_done_i   (fmt_done),
    .resp_done_i   (resp_done),   .wait_cmd_o  (wait_cmd),  .fetch_o      (fetch),
    .xfer_start_o  (xfer_start),  .resp_req_o  (resp_req),  .resp_err_o   (resp_err),
    .idle_o
  );

  i2c_fmt_writer i2c_fmt_writer_i (
    .clk_i, .rst_ni,
    .xfer_start_i (xfer_start), .static_addr_i (static_addr), .data_cnt_i (data_cnt),
    .def_byte_i   (def_byte),   .toc_i         (toc),         .imm_bytes_i (imm_bytes),
    .fmt_valid_o, .fmt_ready_i, .fmt_byte_o, .fmt_start_o, .fmt_stop_o,
    .fmt_done_o   (fmt_done)
  );

  resp_writer resp_writer_i (
    .clk_i, .rst_ni,
    .resp_req_i (resp_req), .resp_err_i (resp_err), .tid_i (tid),
    .resp_valid_o, .resp_ready_i, .resp_data_o,
    .resp_done_o (resp_done)
  );

endmodule

// File: source/resp_writer.sv
// ####################################################################
// Response descriptor build and handshake
// ####################################################################
`timescale 1ns/1ps
`include "i3c_flow_settings.svh"

module resp_writer
  import i3c_flow_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               resp_req_i,
  input  resp_err_e          resp_err_i,
  input  logic [3:0]         tid_i,
  output logic               resp_valid_o,
  input  logic               resp_ready_i,
  output logic [`RESP_W-1:0] resp_data_o,
  output logic               resp_done_o
);

  logic       valid_q;
  resp_err_e  status_q;
  logic [3:0] tid_q;

  // Valid stays up until the queue takes it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (resp_req_i) begin
      valid_q <= 1'b1;
    end else if (resp_done_o) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (resp_req_i) begin
      status_q <= resp_err_i;
      tid_q    <= tid_i;
    end
  end

  // Status, tid, reserved byte, zero data length
  assign resp_data_o  = {status_q, tid_q, 8'h00, 16'h0000};
  assign resp_valid_o = valid_q;
  assign resp_done_o  = valid_q & resp_ready_i;

endmodule

// File: source/i2c_fmt_writer.sv
// ####################################################################
// Byte sequencing toward the I2C format FIFO
// ####################################################################
`timescale 1ns/1ps
`include "i3c_flow_settings.svh"

module i2c_fmt_writer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    xfer_start_i,
  input  logic [6:0]              static_addr_i,
  input  logic [2:0]              data_cnt_i,
  input  logic                    def_byte_i,
  input  logic                    toc_i,
  input  logic [3:0][`BYTE_W-1:0] imm_bytes_i,
  output logic                    fmt_valid_o,
  input  logic                    fmt_ready_i,
  output logic [`BYTE_W-1:0]      fmt_byte_o,
  output logic                    fmt_start_o,
  output logic                    fmt_stop_o,
  output logic                    fmt_done_o
);

  logic       active_q;
  logic [2:0] cnt_q;
  logic [1:0] sel;
  logic       last;
  logic       fire;

  // Address byte is slot 0 and data bytes follow
  assign last = (cnt_q == data_cnt_i);
  assign fire = active_q & fmt_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
    end else if (xfer_start_i) begin
      active_q <= 1'b1;
      cnt_q    <= '0;
    end else if (fire) begin
      // Counter holds under back-pressure
      if (last) begin
        active_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q + 3'd1;
      end
    end
  end

  // Defining byte skips data byte 1
  assign sel = cnt_q[1:0] + {1'b0, def_byte_i} - 2'd1;

  always_comb begin
    if (cnt_q == 3'd0) begin
      // Write direction with the R/W bit low
      fmt_byte_o = {static_addr_i, 1'b0};
    end else begin
      fmt_byte_o = imm_bytes_i[sel];
    end
  end

  assign fmt_valid_o = active_q;
  assign fmt_start_o = (cnt_q == 3'd0);
  assign fmt_stop_o  = last & toc_i;
  assign fmt_done_o  = fire & last;

endmodule

// File: source/flow_sequencer.sv
// ####################################################################
// Transfer state machine routing each command
// ####################################################################
`timescale 1ns/1ps

module flow_sequencer
  import i3c_flow_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      enable_i,
  input  logic      cmd_taken_i,
  input  cmd_attr_e attr_i,
  input  logic      rnw_i,
  input  logic      entry_valid_i,
  input  logic      legacy_i,
  input  logic      fmt_done_i,
  input  logic      resp_done_i,
  output logic      wait_cmd_o,
  output logic      fetch_o,
  output logic      xfer_start_o,
  output logic      resp_req_o,
  output resp_err_e resp_err_o,
  output logic      idle_o
);

  flow_state_e state_q;
  flow_state_e state_d;
  logic        supported;

  // Only immediate writes to legacy I2C targets go on the bus
  assign supported = (attr_i == CmdImmediate) & ~rnw_i & legacy_i;

  always_comb begin
    state_d      = state_q;
    fetch_o      = 1'b0;
    xfer_start_o = 1'b0;
    resp_req_o   = 1'b0;
    unique case (state_q)
      Idle: begin
        if (enable_i) begin
          state_d = WaitCmd;
        end
      end
      WaitCmd: begin
        if (cmd_taken_i) begin
          fetch_o = 1'b1;
          state_d = FetchDat;
        end
      end
      FetchDat: begin
        // Single routing decision when the entry returns
        if (entry_valid_i) begin
          if (supported) begin
            xfer_start_o = 1'b1;
            state_d      = I2cWriteImm;
          end else begin
            resp_req_o = 1'b1;
            state_d    = WriteResp;
          end
        end
      end
      I2cWriteImm: begin
        if (fmt_done_i) begin
          resp_req_o = 1'b1;
          state_d    = WriteResp;
        end
      end
      WriteResp: begin
        if (resp_done_i) begin
          state_d = Idle;
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Status only differs by the state raising the request
  assign resp_err_o = (state_q == I2cWriteImm) ? RespSuccess : RespUnsupported;
  assign wait_cmd_o = (state_q == WaitCmd);
  assign idle_o     = (state_q == Idle) | (state_q == WaitCmd);

endmodule

// File: source/dat_reader.sv
// ####################################################################
// DAT read strobe and entry capture
// ####################################################################
`timescale 1ns/1ps
`include "i3c_flow_settings.svh"

module dat_reader (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  fetch_i,
  input  logic [`DAT_IDX_W-1:0] dev_idx_i,
  output logic                  dat_rd_o,
  output logic [`DAT_IDX_W-1:0] dat_idx_o,
  input  logic [`DAT_W-1:0]     dat_rdata_i,
  output logic                  entry_valid_o,
  output logic [6:0]            static_addr_o,
  output logic                  legacy_o
);

  logic              rd_q;
  logic              rd_dly_q;
  logic [`DAT_W-1:0] entry_q;
  logic [`DAT_W-1:0] entry;

  // Strobe one cycle after fetch, then its delayed copy marks returned data
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_q     <= 1'b0;
      rd_dly_q <= 1'b0;
    end else begin
      rd_q     <= fetch_i;
      rd_dly_q <= rd_q;
    end
  end

  assign dat_rd_o  = rd_q;
  assign dat_idx_o = dev_idx_i;

  always_ff @(posedge clk_i) begin
    if (rd_dly_q) begin
      entry_q <= dat_rdata_i;
    end
  end

  // Returned data is visible in its arrival cycle for the routing decision
  assign entry_valid_o = rd_dly_q;
  assign entry         = rd_dly_q ? dat_rdata_i : entry_q;
  assign static_addr_o = entry[`DAT_ADDR_LSB +: 7];
  assign legacy_o      = entry[`DAT_LEGACY_BIT];

endmodule

// File: source/cmd_decoder.sv
// ####################################################################
// Command intake and descriptor field decode
// ####################################################################
`timescale 1ns/1ps
`include "i3c_flow_settings.svh"

module cmd_decoder
  import i3c_flow_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            cmd_valid_i,
  input  logic [`CMD_W-1:0]               cmd_data_i,
  output logic                            cmd_ready_o,
  input  logic                            wait_cmd_i,
  output logic                            cmd_taken_o,
  output logic [`DAT_IDX_W-1:0]           dev_idx_o,
  output logic [3:0]                      tid_o,
  output cmd_attr_e                       attr_o,
  output logic                            rnw_o,
  output logic                            toc_o,
  output logic [2:0]                      data_cnt_o,
  output logic                            def_byte_o,
  output logic [3:0][`BYTE_W-1:0]         imm_bytes_o
);

  logic [`CMD_W-1:0] desc_q;
  logic [2:0]        dtt;

  // Queue only open while the sequencer waits for a command
  assign cmd_ready_o = wait_cmd_i;
  assign cmd_taken_o = cmd_valid_i & wait_cmd_i;

  // Descriptor held until the next accepted command
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      desc_q <= '0;
    end else if (cmd_taken_o) begin
      desc_q <= cmd_data_i;
    end
  end

  // Generic fields
  assign dev_idx_o = desc_q[`CMD_DEV_IDX];
  assign tid_o     = desc_q[`CMD_TID];
  assign attr_o    = cmd_attr_e'(desc_q[`CMD_ATTR]);
  assign rnw_o     = desc_q[`CMD_RNW];
  assign toc_o     = desc_q[`CMD_TOC];

  // dtt 5..7 means defining byte plus dtt-5 data bytes
  assign dtt        = desc_q[`CMD_DTT];
  assign def_byte_o = (dtt >= `DTT_DEF_BYTE_MIN);
  assign data_cnt_o = def_byte_o ? dtt - 3'(`DTT_DEF_BYTE_MIN) : dtt;

  // Immediate payload with entry 0 as data byte 1
  assign imm_bytes_o[0] = desc_q[`CMD_BYTE1];
  assign imm_bytes_o[1] = desc_q[`CMD_BYTE2];
  assign imm_bytes_o[2] = desc_q[`CMD_BYTE3];
  assign imm_bytes_o[3] = desc_q[`CMD_BYTE4];

endmodule

// File: source/i3c_flow_pkg.sv
// ####################################################################
// Shared enums for the I3C active flow
// ####################################################################
package i3c_flow_pkg;

  // Command attribute in the low three descriptor bits
  typedef enum logic [2:0] {
    CmdRegular    = 3'd0,
    CmdImmediate  = 3'd1,
    CmdAddrAssign = 3'd2,
    CmdCombo      = 3'd3,
    // 4..6 reserved
    CmdInternal   = 3'd7
  } cmd_attr_e;

  // Response status field
  typedef enum logic [3:0] {
    RespSuccess     = 4'd0,
    // Anything outside immediate I2C writes
    RespUnsupported = 4'd12
  } resp_err_e;

  // Transfer sequencer states
  typedef enum logic [2:0] {
    // Parked until enabled
    Idle,
    // Command queue open
    WaitCmd,
    // DAT read in flight
    FetchDat,
    // Bytes going to the I2C format FIFO
    I2cWriteImm,
    // Response descriptor waiting for the queue
    WriteResp
  } flow_state_e;

endpackage

// File: source/i3c_flow_settings.svh
// ####################################################################
// Widths and bit positions for the I3C active flow
// ####################################################################
`ifndef I3C_FLOW_SETTINGS_SVH
`define I3C_FLOW_SETTINGS_SVH

// Queue and table widths
`define CMD_W 64
`define RESP_W 32
`define DAT_W 64
`define DAT_IDX_W 5
`define BYTE_W 8

// Command descriptor fields
`define CMD_ATTR 2:0
`define CMD_TID 6:3
`define CMD_DEV_IDX 20:16
`define CMD_DTT 25:23
`define CMD_RNW 29
`define CMD_TOC 31
`define CMD_BYTE1 39:32
`define CMD_BYTE2 47:40
`define CMD_BYTE3 55:48
`define CMD_BYTE4 63:56

// DAT entry fields
`define DAT_ADDR_LSB 0
`define DAT_LEGACY_BIT 31

// First dtt code carrying a defining byte
`define DTT_DEF_BYTE_MIN 5

`endif
